//--- dv/priv_unit_asserts.sv
// Concurrent checks bound to the privileged unit top level
// Quiet redirect after reset, stall holding back interrupts, legal mode

`timescale 1ns/100ps
`default_nettype none

module priv_unit_asserts (
    input logic       clk,
    input logic       rst_n,
    input logic       insert_pc,
    input logic       intr,
    input logic       ex_mem_stall,
    input logic       mret,
    input logic       sret,
    input logic [1:0] curr_mode
);

    int fail_count = 0;  // Summed into the end-of-run error count

    // All CSRs are zero out of reset, so no interrupt can be enabled
    assert property (@(posedge clk) ($rose(rst_n) && !mret && !sret) |-> !insert_pc)
        else begin
            fail_count++;
            $error("insert_pc high in the first cycle after reset with no return strobe");
        end

    // Stall holds back interrupt entry when no return retires
    assert property (@(posedge clk) disable iff (!rst_n)
                     (intr && ex_mem_stall && !mret && !sret) |-> !insert_pc)
        else begin
            fail_count++;
            $error("insert_pc high for an interrupt during ex_mem_stall");
        end

    assert property (@(posedge clk) disable iff (!rst_n) curr_mode != 2'd2)
        else begin
            fail_count++;
            $error("curr_mode holds the reserved privilege encoding");
        end

endmodule

bind priv_unit priv_unit_asserts u_asserts (
    .clk          (clk),
    .rst_n        (rst_n),
    .insert_pc    (insert_pc),
    .intr         (sel.intr),  // Arbiter result inside the top level
    .ex_mem_stall (ex_mem_stall),
    .mret         (mret),
    .sret         (sret),
    .curr_mode    (curr_mode)
);

`default_nettype wire

//--- dv/priv_unit_tb.sv
// Testbench for the privileged trap-redirect unit
// Clock, reset and seeded random stimulus on the falling edge
// Reference model of the CSRs, privilege mode and redirect rules

`timescale 1ns/100ps
`default_nettype none

module priv_unit_tb;

    import priv_isa_types_pkg::*;
    import priv_unit_types_pkg::*;

    logic        clk;
    logic        rst_n;
    irq_vec_t    irq_lines;
    logic        ex_mem_stall;
    logic        mret;
    logic        sret;
    word_t       epc;
    csr_wr_req_t csr_wr;
    csr_addr_t   csr_raddr;
    word_t       csr_rdata;
    logic        insert_pc;
    word_t       priv_pc;
    priv_level_t curr_mode;

    word_t      m_mstatus, m_mie, m_mideleg;  // Model CSRs
    word_t      m_mtvec, m_mepc, m_mcause;
    word_t      m_stvec, m_sepc, m_scause;
    logic [1:0] m_mode;
    logic       e_intr, e_to_s, e_insert;     // Predictions for this cycle
    int         e_code;
    word_t      e_pc, e_rdata;
    logic       seen_insert;
    logic       timed_out;
    int         errors;

    priv_unit DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .irq_lines    (irq_lines),
        .ex_mem_stall (ex_mem_stall),
        .mret         (mret),
        .sret         (sret),
        .epc          (epc),
        .csr_wr       (csr_wr),
        .csr_raddr    (csr_raddr),
        .csr_rdata    (csr_rdata),
        .insert_pc    (insert_pc),
        .priv_pc      (priv_pc),
        .curr_mode    (curr_mode)
    );

    always #20 clk = ~clk;  // 40 ns period

    // SIE MIE SPIE MPIE SPP MPP kept, reserved MPP reads as U
    function automatic word_t legal_status(input word_t d);
        word_t v;
        v = d & 32'h0000_19AA;
        if (v[12:11] == 2'b10) begin
            v[12:11] = 2'b00;
        end
        return v;
    endfunction

    function automatic csr_addr_t rand_addr();
        case ($urandom_range(0, 10))
            0:       return CSR_MSTATUS;
            1:       return CSR_MIE;
            2:       return CSR_MIDELEG;
            3:       return CSR_MTVEC;
            4:       return CSR_MEPC;
            5:       return CSR_MCAUSE;
            6:       return CSR_MIP;
            7:       return CSR_STVEC;
            8:       return CSR_SEPC;
            9:       return CSR_SCAUSE;
            default: return csr_addr_t'($urandom);  // Mostly unknown addresses
        endcase
    endfunction

    task automatic compare(input string name, input string what, input word_t exp,
                           input word_t act);
        assert (act === exp) else begin
            errors++;
            $display("FAILED %s: %s expected %h actual %h", name, what, exp, act);
        end
    endtask

    task automatic predict();
        int       prio [6] = '{11, 3, 7, 9, 1, 5};  // MEI MSI MTI SEI SSI STI
        irq_vec_t pend;
        logic     m_glb;
        logic     s_glb;
        word_t    tv;
        pend   = irq_lines & m_mie[11:0];
        m_glb  = (m_mode != 2'd3) || m_mstatus[3];
        s_glb  = (m_mode == 2'd0) || (m_mode == 2'd1 && m_mstatus[1]);
        e_intr = 1'b0;
        e_to_s = 1'b0;
        e_code = 0;
        foreach (prio[k]) begin
            if (!e_intr && pend[prio[k]] && (m_mideleg[prio[k]] ? s_glb : m_glb)) begin
                e_intr = 1'b1;
                e_to_s = m_mideleg[prio[k]];
                e_code = prio[k];
            end
        end
        e_insert = mret || sret || (e_intr && !ex_mem_stall);
        tv       = e_to_s ? m_stvec : m_mtvec;
        if (e_intr) begin
            e_pc = {tv[31:2], 2'b00} + ((tv[1:0] == 2'd1) ? 32'(e_code) * 4 : 32'd0);
        end else begin
            e_pc = mret ? m_mepc : (sret ? m_sepc : 32'd0);
        end
        case (csr_raddr)
            CSR_MSTATUS: e_rdata = m_mstatus;
            CSR_MIE:     e_rdata = m_mie;
            CSR_MIDELEG: e_rdata = m_mideleg;
            CSR_MTVEC:   e_rdata = m_mtvec;
            CSR_MEPC:    e_rdata = m_mepc;
            CSR_MCAUSE:  e_rdata = m_mcause;
            CSR_MIP:     e_rdata = {20'd0, irq_lines};
            CSR_STVEC:   e_rdata = m_stvec;
            CSR_SEPC:    e_rdata = m_sepc;
            CSR_SCAUSE:  e_rdata = m_scause;
            default:     e_rdata = '0;
        endcase
    endtask

    // Software write first, a commit in the same cycle overrides it
    task automatic update_model();
        word_t      st;
        logic [1:0] md;
        st = m_mstatus;
        md = m_mode;
        if (csr_wr.en) begin
            case (csr_wr.addr)
                CSR_MSTATUS: m_mstatus = legal_status(csr_wr.data);
                CSR_MIE:     m_mie     = csr_wr.data & 32'h0000_0AAA;
                CSR_MIDELEG: m_mideleg = csr_wr.data & 32'h0000_0222;  // Bits 1 5 9
                CSR_MTVEC:   m_mtvec   = {csr_wr.data[31:2], 1'b0, csr_wr.data[1:0] == 2'd1};
                CSR_MEPC:    m_mepc    = csr_wr.data & ~32'd3;
                CSR_MCAUSE:  m_mcause  = csr_wr.data;
                CSR_STVEC:   m_stvec   = {csr_wr.data[31:2], 1'b0, csr_wr.data[1:0] == 2'd1};
                CSR_SEPC:    m_sepc    = csr_wr.data & ~32'd3;
                CSR_SCAUSE:  m_scause  = csr_wr.data;
                default:     ;
            endcase
        end
        if (e_insert) begin
            if (e_intr && e_to_s) begin
                st[5]    = st[1];     // SPIE from SIE
                st[1]    = 1'b0;
                st[8]    = (md != 2'd0);
                m_sepc   = epc & ~32'd3;
                m_scause = {1'b1, 31'(e_code)};
                m_mode   = 2'd1;
            end else if (e_intr) begin
                st[7]     = st[3];    // MPIE from MIE
                st[3]     = 1'b0;
                st[12:11] = md;
                m_mepc    = epc & ~32'd3;
                m_mcause  = {1'b1, 31'(e_code)};
                m_mode    = 2'd3;
            end else if (mret) begin
                m_mode    = st[12:11];
                st[3]     = st[7];
                st[7]     = 1'b1;
                st[12:11] = 2'd0;
            end else begin
                m_mode = st[8] ? 2'd1 : 2'd0;
                st[1]  = st[5];
                st[5]  = 1'b1;
                st[8]  = 1'b0;
            end
            m_mstatus = legal_status(st);
        end
    endtask

    // One cycle from a falling edge to the next, checked before the rising edge
    task automatic tick(input string name);
        #10;
        predict();
        seen_insert = insert_pc;
        compare(name, "insert_pc", 32'(e_insert), 32'(insert_pc));
        compare(name, "priv_pc", e_pc, priv_pc);
        compare(name, "csr_rdata", e_rdata, csr_rdata);
        compare(name, "curr_mode", 32'(m_mode), 32'(curr_mode));
        @(posedge clk);
        update_model();
        @(negedge clk);
        mret      = 1'b0;  // Strobes last one cycle
        sret      = 1'b0;
        csr_wr.en = 1'b0;
    endtask

    task automatic csr_write(input csr_addr_t addr, input word_t data, input string name);
        csr_wr = '{en: 1'b1, addr: addr, data: data};
        tick(name);
    endtask

    task automatic read_csr(input csr_addr_t addr, input string name);
        csr_raddr = addr;
        tick(name);
    endtask

    // Stall for a number of cycles, then expect the redirect shortly after
    task automatic wait_redirect(input string name, input int stall_cycles);
        int n;
        seen_insert = 1'b0;
        for (n = 0; n < stall_cycles + 4 && !seen_insert; n++) begin
            ex_mem_stall = (n < stall_cycles);
            tick(name);
        end
        ex_mem_stall = 1'b0;
        if (!seen_insert) begin
            timed_out = 1'b1;
            $display("Timeout in %s: no redirect within %0d cycles", name, n);
        end
    endtask

    // MTI is never delegated, so it pulls a lower mode back into M
    task automatic to_machine(input string name);
        if (m_mode != 2'd3) begin
            irq_lines = 12'h080;
            csr_wr    = '{en: 1'b1, addr: CSR_MIE, data: 32'h0000_0AAA};
            wait_redirect(name, 0);
            irq_lines = '0;
        end
    endtask

    initial begin
        void'($urandom(32'h7d4f));
        clk          = 1'b0;
        rst_n        = 1'b0;
        irq_lines    = '0;
        ex_mem_stall = 1'b0;
        mret         = 1'b0;
        sret         = 1'b0;
        epc          = '0;
        csr_wr       = '0;
        csr_raddr    = '0;
        errors       = 0;
        timed_out    = 1'b0;
        m_mstatus    = '0;
        m_mie        = '0;
        m_mideleg    = '0;
        m_mtvec      = '0;
        m_mepc       = '0;
        m_mcause     = '0;
        m_stvec      = '0;
        m_sepc       = '0;
        m_scause     = '0;
        m_mode       = 2'd3;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        tick("reset");

        for (int i = 0; i < 60; i++) begin  // Write then read back, masks and mip
            irq_lines = irq_vec_t'($urandom);
            csr_raddr = rand_addr();
            csr_write(csr_raddr, $urandom, "csr_rw");
            tick("csr_rw");
        end

        for (int i = 0; i < 8 && !timed_out; i++) begin  // M entry, DIRECT and VECTORED
            irq_lines = '0;
            csr_write(CSR_MIDELEG, 32'd0, "m_entry");
            csr_write(CSR_MIE, 32'h0000_0AAA, "m_entry");
            csr_write(CSR_MTVEC, ($urandom & ~32'd3) | 32'(i % 2), "m_entry");
            csr_write(CSR_MSTATUS, 32'h0000_0008, "m_entry");
            epc       = $urandom;
            irq_lines = irq_vec_t'($urandom) | 12'h008;  // MSI plus random others
            wait_redirect("m_entry", $urandom_range(0, 3));
            irq_lines = '0;
            read_csr(CSR_MEPC, "m_entry");
            read_csr(CSR_MCAUSE, "m_entry");
            read_csr(CSR_MSTATUS, "m_entry");
        end

        for (int i = 0; i < 8 && !timed_out; i++) begin  // Delegation to S
            csr_write(CSR_MIDELEG, 32'h0000_0222, "deleg");
            csr_write(CSR_STVEC, $urandom, "deleg");
            csr_write(CSR_MEPC, $urandom, "deleg");
            csr_write(CSR_MSTATUS, 32'h0000_000A | 32'((i % 2) << 11), "deleg");  // MPP S or U
            irq_lines = irq_vec_t'($urandom & 32'h222) | 12'h020;
            tick("deleg_in_m");  // Delegated lines stay masked in M
            tick("deleg_in_m");
            mret = 1'b1;
            tick("deleg");
            epc = $urandom;
            wait_redirect("deleg", $urandom_range(0, 3));
            irq_lines = '0;
            read_csr(CSR_SEPC, "deleg");
            read_csr(CSR_SCAUSE, "deleg");
            to_machine("deleg");
        end

        for (int i = 0; i < 10 && !timed_out; i++) begin  // mret and sret
            csr_write(CSR_MEPC, $urandom, "returns");
            csr_write(CSR_SEPC, $urandom, "returns");
            csr_write(CSR_MSTATUS, $urandom & ~32'h8, "returns");
            mret = 1'b1;
            tick("returns");
            sret = 1'b1;
            tick("returns");
            read_csr(CSR_MSTATUS, "returns");
            to_machine("returns");
            csr_write(CSR_MSTATUS, 32'h0000_0008, "intr_vs_mret");
            irq_lines    = 12'h800;  // MEI with a simultaneous mret
            ex_mem_stall = i % 2;
            mret         = 1'b1;
            tick("intr_vs_mret");
            ex_mem_stall = 1'b0;
            irq_lines    = '0;
        end

        if (!timed_out) begin  // Masking by MIE, mie and SIE
            csr_write(CSR_MSTATUS, 32'd0, "mask");
            irq_lines = 12'hAAA;
            for (int i = 0; i < 3; i++) begin
                tick("mask_mie_off");
            end
            csr_write(CSR_MIE, 32'd0, "mask");
            csr_write(CSR_MSTATUS, 32'h0000_0008, "mask");
            for (int i = 0; i < 3; i++) begin
                tick("mask_mie_bits");
            end
            irq_lines = '0;
            csr_write(CSR_MIE, 32'h0000_0AAA, "mask");
            csr_write(CSR_MSTATUS, 32'h0000_0800, "mask");  // MPP S, SIE clear
            mret = 1'b1;
            tick("mask");
            irq_lines = 12'h222;
            for (int i = 0; i < 3; i++) begin
                tick("mask_sie_off");
            end
            irq_lines = '0;
            to_machine("mask");
        end

        for (int i = 0; i < 2000 && !timed_out; i++) begin
            irq_lines    = irq_vec_t'($urandom);
            ex_mem_stall = ($urandom_range(0, 3) == 0);
            mret         = ($urandom_range(0, 9) == 0);
            sret         = ($urandom_range(0, 9) == 0);
            epc          = $urandom;
            csr_wr       = '{en: ($urandom_range(0, 3) == 0), addr: rand_addr(), data: $urandom};
            csr_raddr    = rand_addr();
            tick("random_mix");
        end

        $display("Errors: %0d mismatches, %0d assertion failures, %0d timeouts",
                 errors, DUT.u_asserts.fail_count, timed_out);
        if (errors == 0 && DUT.u_asserts.fail_count == 0 && !timed_out) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
src/priv_isa_types_pkg.sv
src/priv_unit_types_pkg.sv
src/priv_csr_bank.sv
src/priv_intr_arbiter.sv
src/priv_mode_ctrl.sv
src/priv_pipe_control.sv
src/priv_unit.sv
dv/priv_unit_asserts.sv
dv/priv_unit_tb.sv

//--- src/priv_csr_bank.sv
// Privileged CSR bank
// Software write and combinational read port
// Trap and return commit port for xepc, xcause and mstatus

`timescale 1ns/100ps
`default_nettype none

module priv_csr_bank (
    input  logic                               clk,
    input  logic                               rst_n,
    input  priv_unit_types_pkg::csr_wr_req_t   csr_wr,
    input  priv_isa_types_pkg::csr_addr_t      csr_raddr,
    input  priv_isa_types_pkg::irq_vec_t       irq_lines,
    input  priv_unit_types_pkg::trap_commit_t  commit,
    output priv_isa_types_pkg::word_t          csr_rdata,
    output priv_unit_types_pkg::trap_view_t    view,
    output priv_isa_types_pkg::word_t          mstatus,
    output priv_isa_types_pkg::word_t          mie,
    output priv_isa_types_pkg::word_t          mideleg
);

    import priv_isa_types_pkg::*;

    word_t  mstatus_q;
    word_t  mie_q;
    word_t  mideleg_q;
    tvec_t  mtvec_q;
    word_t  mepc_q;
    cause_t mcause_q;
    tvec_t  stvec_q;
    word_t  sepc_q;
    cause_t scause_q;

    // Keeps status fields only; reserved MPP value falls back to U
    function automatic word_t legal_mstatus(input word_t d);
        word_t v;
        v = d & MSTATUS_WMASK;
        if (v[MSTATUS_MPP_HI:MSTATUS_MPP_LO] == 2'b10) begin
            v[MSTATUS_MPP_HI:MSTATUS_MPP_LO] = U;
        end
        return v;
    endfunction

    function automatic tvec_t legal_tvec(input word_t d);
        tvec_t t;
        t.base = d[31:2];
        t.mode = (d[1:0] == 2'd1) ? VECTORED : DIRECT;  // Modes above 1 read as DIRECT
        return t;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mstatus_q <= '0;   // Global MIE off out of reset
            mie_q     <= '0;
            mideleg_q <= '0;
            mtvec_q   <= '0;
            mepc_q    <= '0;
            mcause_q  <= '0;
            stvec_q   <= '0;
            sepc_q    <= '0;
            scause_q  <= '0;
        end else begin
            if (csr_wr.en) begin
                case (csr_wr.addr)
                    CSR_MSTATUS: mstatus_q <= legal_mstatus(csr_wr.data);
                    CSR_MIE:     mie_q     <= csr_wr.data & MIE_WMASK;
                    CSR_MIDELEG: mideleg_q <= csr_wr.data & MIDELEG_WMASK;
                    CSR_MTVEC:   mtvec_q   <= legal_tvec(csr_wr.data);
                    CSR_MEPC:    mepc_q    <= {csr_wr.data[31:2], 2'b00};
                    CSR_MCAUSE:  mcause_q  <= csr_wr.data;
                    CSR_STVEC:   stvec_q   <= legal_tvec(csr_wr.data);
                    CSR_SEPC:    sepc_q    <= {csr_wr.data[31:2], 2'b00};
                    CSR_SCAUSE:  scause_q  <= csr_wr.data;
                    default:     ;         // mip and unknown addresses ignore writes
                endcase
            end
            // Commit comes last so it wins over a software write
            if (commit.status_we) begin
                mstatus_q <= legal_mstatus(commit.mstatus_next);
            end
            if (commit.en_m) begin
                mepc_q   <= {commit.epc[31:2], 2'b00};
                mcause_q <= commit.cause;
            end
            if (commit.en_s) begin
                sepc_q   <= {commit.epc[31:2], 2'b00};
                scause_q <= commit.cause;
            end
        end
    end

    always_comb begin
        case (csr_raddr)
            CSR_MSTATUS: csr_rdata = mstatus_q;
            CSR_MIE:     csr_rdata = mie_q;
            CSR_MIDELEG: csr_rdata = mideleg_q;
            CSR_MTVEC:   csr_rdata = mtvec_q;
            CSR_MEPC:    csr_rdata = mepc_q;
            CSR_MCAUSE:  csr_rdata = mcause_q;
            CSR_MIP:     csr_rdata = {20'd0, irq_lines};  // Mirrors the live lines
            CSR_STVEC:   csr_rdata = stvec_q;
            CSR_SEPC:    csr_rdata = sepc_q;
            CSR_SCAUSE:  csr_rdata = scause_q;
            default:     csr_rdata = '0;
        endcase
    end

    assign view    = '{mtvec: mtvec_q, stvec: stvec_q, mepc: mepc_q, sepc: sepc_q};
    assign mstatus = mstatus_q;
    assign mie     = mie_q;
    assign mideleg = mideleg_q;

endmodule

`default_nettype wire

//--- src/priv_intr_arbiter.sv
// Interrupt arbiter
// Enable masking, S-mode delegation and global enables
// Fixed-priority pick of one pending interrupt

`timescale 1ns/100ps
`default_nettype none

module priv_intr_arbiter (
    input  priv_isa_types_pkg::irq_vec_t     irq_lines,
    input  priv_isa_types_pkg::word_t        mie,
    input  priv_isa_types_pkg::word_t        mideleg,
    input  priv_isa_types_pkg::word_t        mstatus,
    input  priv_isa_types_pkg::priv_level_t  curr_mode,
    output priv_unit_types_pkg::intr_sel_t   sel
);

    import priv_isa_types_pkg::*;

    irq_vec_t pending;  // Pending and individually enabled
    irq_vec_t deleg;    // Delegated to S
    irq_vec_t take;     // Passes its global enable
    logic     m_glb;
    logic     s_glb;

    assign pending = irq_lines & mie[IRQ_W-1:0];
    assign deleg   = mideleg[IRQ_W-1:0];

    // Lower mode is always interruptible by a higher target
    assign m_glb = (curr_mode != M) || mstatus[MSTATUS_MIE];
    assign s_glb = (curr_mode == U) || ((curr_mode == S) && mstatus[MSTATUS_SIE]);

    // Delegated lines stay masked while in M, s_glb is low there
    assign take = (pending & ~deleg & {IRQ_W{m_glb}})
                | (pending &  deleg & {IRQ_W{s_glb}});

    // Walk from lowest to highest priority so the highest hit wins
    always_comb begin
        sel = '0;
        for (int i = IRQ_NUM - 1; i >= 0; i--) begin
            if (take[IRQ_PRIO[i]]) begin
                sel.intr            = 1'b1;
                sel.intr_to_s       = deleg[IRQ_PRIO[i]];
                sel.cause.interrupt = 1'b1;
                sel.cause.cause     = 31'(IRQ_PRIO[i]);
            end
        end
    end

endmodule

`default_nettype wire

//--- src/priv_isa_types_pkg.sv
// ISA-level definitions for the RV32 privileged unit
// Word, CSR address and interrupt vector types
// Privilege levels, trap vector and cause formats
// CSR addresses, interrupt codes, mstatus fields and write masks

`default_nettype none

package priv_isa_types_pkg;

    localparam int XLEN  = 32;  // Data and address width
    localparam int IRQ_W = 12;  // Standard interrupt bit positions

    typedef logic [XLEN-1:0]  word_t;
    typedef logic [11:0]      csr_addr_t;
    typedef logic [IRQ_W-1:0] irq_vec_t;

    typedef enum logic [1:0] {
        U = 2'd0,
        S = 2'd1,
        M = 2'd3   // Encoding 2 is reserved
    } priv_level_t;

    typedef enum logic [1:0] {
        DIRECT   = 2'd0,
        VECTORED = 2'd1
    } tvec_mode_t;

    typedef struct packed {
        logic [29:0] base;  // Word-aligned handler base
        tvec_mode_t  mode;
    } tvec_t;

    typedef struct packed {
        logic        interrupt;  // Set for asynchronous causes
        logic [30:0] cause;
    } cause_t;

    // Interrupt codes, also the bit positions in mip/mie/mideleg
    localparam int SSI = 1;
    localparam int MSI = 3;
    localparam int STI = 5;
    localparam int MTI = 7;
    localparam int SEI = 9;
    localparam int MEI = 11;

    // Fixed priority, highest first
    localparam int IRQ_NUM = 6;
    localparam int IRQ_PRIO [IRQ_NUM] = '{MEI, MSI, MTI, SEI, SSI, STI};

    localparam csr_addr_t CSR_MSTATUS = 12'h300;
    localparam csr_addr_t CSR_MIDELEG = 12'h303;
    localparam csr_addr_t CSR_MIE     = 12'h304;
    localparam csr_addr_t CSR_MTVEC   = 12'h305;
    localparam csr_addr_t CSR_MEPC    = 12'h341;
    localparam csr_addr_t CSR_MCAUSE  = 12'h342;
    localparam csr_addr_t CSR_MIP     = 12'h344;
    localparam csr_addr_t CSR_STVEC   = 12'h105;
    localparam csr_addr_t CSR_SEPC    = 12'h141;
    localparam csr_addr_t CSR_SCAUSE  = 12'h142;

    localparam int MSTATUS_SIE    = 1;
    localparam int MSTATUS_MIE    = 3;
    localparam int MSTATUS_SPIE   = 5;
    localparam int MSTATUS_MPIE   = 7;
    localparam int MSTATUS_SPP    = 8;
    localparam int MSTATUS_MPP_LO = 11;
    localparam int MSTATUS_MPP_HI = 12;

    localparam word_t MSTATUS_WMASK = 32'h0000_19AA;  // SIE MIE SPIE MPIE SPP MPP
    localparam word_t MIE_WMASK     = 32'h0000_0AAA;  // All six standard enables
    localparam word_t MIDELEG_WMASK = 32'h0000_0222;  // S-level interrupts only

endpackage

`default_nettype wire

//--- src/priv_mode_ctrl.sv
// Privilege-mode FSM
// Selects trap or return on each redirect
// Builds the commit update for xepc, xcause and mstatus

`timescale 1ns/100ps
`default_nettype none

module priv_mode_ctrl (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               insert_pc,
    input  priv_unit_types_pkg::intr_sel_t     sel,
    input  logic                               mret,
    input  logic                               sret,
    input  priv_isa_types_pkg::word_t          epc,
    input  priv_isa_types_pkg::word_t          mstatus,
    output priv_isa_types_pkg::priv_level_t    curr_mode,
    output priv_unit_types_pkg::trap_commit_t  commit
);

    import priv_isa_types_pkg::*;

    priv_level_t next_mode;
    word_t       st;  // mstatus after this event

    always_comb begin
        next_mode    = curr_mode;
        st           = mstatus;
        commit       = '0;
        commit.epc   = epc;
        commit.cause = sel.cause;
        if (insert_pc) begin
            if (sel.intr) begin  // Interrupt beats both returns
                commit.status_we = 1'b1;
                if (sel.intr_to_s) begin
                    commit.en_s       = 1'b1;
                    st[MSTATUS_SPIE]  = st[MSTATUS_SIE];
                    st[MSTATUS_SIE]   = 1'b0;
                    st[MSTATUS_SPP]   = (curr_mode != U);  // Only U or S reach here
                    next_mode         = S;
                end else begin
                    commit.en_m       = 1'b1;
                    st[MSTATUS_MPIE]  = st[MSTATUS_MIE];
                    st[MSTATUS_MIE]   = 1'b0;
                    st[MSTATUS_MPP_HI:MSTATUS_MPP_LO] = curr_mode;
                    next_mode         = M;
                end
            end else if (mret) begin
                commit.status_we = 1'b1;
                next_mode        = priv_level_t'(st[MSTATUS_MPP_HI:MSTATUS_MPP_LO]);
                st[MSTATUS_MIE]  = st[MSTATUS_MPIE];
                st[MSTATUS_MPIE] = 1'b1;
                st[MSTATUS_MPP_HI:MSTATUS_MPP_LO] = U;
            end else if (sret) begin
                commit.status_we = 1'b1;
                next_mode        = st[MSTATUS_SPP] ? S : U;
                st[MSTATUS_SIE]  = st[MSTATUS_SPIE];
                st[MSTATUS_SPIE] = 1'b1;
                st[MSTATUS_SPP]  = 1'b0;
            end
        end
        commit.mstatus_next = st;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            curr_mode <= M;  // Boot in machine mode
        end else begin
            curr_mode <= next_mode;
        end
    end

endmodule

`default_nettype wire

//--- src/priv_pipe_control.sv
// Pipeline redirect control
// Redirect strobe for interrupts, mret and sret
// Target PC from trap vectors or saved epc

`timescale 1ns/100ps
`default_nettype none

module priv_pipe_control (
    input  priv_unit_types_pkg::intr_sel_t   sel,
    input  priv_unit_types_pkg::trap_view_t  view,
    input  logic                             mret,
    input  logic                             sret,
    input  logic                             ex_mem_stall,
    output logic                             insert_pc,
    output priv_isa_types_pkg::word_t        priv_pc
);

    import priv_isa_types_pkg::*;

    tvec_t tvec;  // Vector of the target mode

    // Stall holds back interrupt entry only
    assign insert_pc = mret | sret | (sel.intr & ~ex_mem_stall);

    assign tvec = sel.intr_to_s ? view.stvec : view.mtvec;

    always_comb begin
        priv_pc = '0;
        if (sel.intr) begin
            if (tvec.mode == VECTORED) begin
                priv_pc = {tvec.base, 2'b00} + {sel.cause.cause[29:0], 2'b00};  // base + 4*code
            end else begin
                priv_pc = {tvec.base, 2'b00};
            end
        end else if (mret) begin
            priv_pc = view.mepc;  // Back from M handler
        end else if (sret) begin
            priv_pc = view.sepc;  // Back from S handler
        end
    end

endmodule

`default_nettype wire

//--- src/priv_unit.sv
// Trap-redirect top level of the RV32 privileged unit
// CSR bank, interrupt arbiter, pipe control and mode FSM

`timescale 1ns/100ps
`default_nettype none

module priv_unit (
    input  logic                              clk,
    input  logic                              rst_n,
    input  priv_isa_types_pkg::irq_vec_t      irq_lines,
    input  logic                              ex_mem_stall,
    input  logic                              mret,
    input  logic                              sret,
    input  priv_isa_types_pkg::word_t         epc,
    input  priv_unit_types_pkg::csr_wr_req_t  csr_wr,
    input  priv_isa_types_pkg::csr_addr_t     csr_raddr,
    output priv_isa_types_pkg::word_t         csr_rdata,
    output logic                              insert_pc,
    output priv_isa_types_pkg::word_t         priv_pc,
    output priv_isa_types_pkg::priv_level_t   curr_mode
);

    import priv_isa_types_pkg::*;
    import priv_unit_types_pkg::*;

    trap_view_t   view;
    trap_commit_t commit;
    intr_sel_t    sel;
    word_t        mstatus;
    word_t        mie;
    word_t        mideleg;

    priv_csr_bank u_csr_bank (
        .clk       (clk),
        .rst_n     (rst_n),
        .csr_wr    (csr_wr),
        .csr_raddr (csr_raddr),
        .irq_lines (irq_lines),
        .commit    (commit),
        .csr_rdata (csr_rdata),
        .view      (view),
        .mstatus   (mstatus),
        .mie       (mie),
        .mideleg   (mideleg)
    );

    priv_intr_arbiter u_intr_arbiter (
        .irq_lines (irq_lines),
        .mie       (mie),
        .mideleg   (mideleg),
        .mstatus   (mstatus),
        .curr_mode (curr_mode),
        .sel       (sel)
    );

    priv_pipe_control u_pipe_control (
        .sel          (sel),
        .view         (view),
        .mret         (mret),
        .sret         (sret),
        .ex_mem_stall (ex_mem_stall),
        .insert_pc    (insert_pc),
        .priv_pc      (priv_pc)
    );

    priv_mode_ctrl u_mode_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .insert_pc (insert_pc),  // Sole commit qualifier
        .sel       (sel),
        .mret      (mret),
        .sret      (sret),
        .epc       (epc),
        .mstatus   (mstatus),
        .curr_mode (curr_mode),
        .commit    (commit)
    );

endmodule

`default_nettype wire

//--- src/priv_unit_types_pkg.sv
// Transport types between the privileged unit's blocks
// Software CSR write request, trap commit update
// CSR view for pipe control and arbiter selection result

`default_nettype none

package priv_unit_types_pkg;

    import priv_isa_types_pkg::*;

    typedef struct packed {
        logic      en;    // Write this cycle
        csr_addr_t addr;
        word_t     data;
    } csr_wr_req_t;       // 45 bits

    typedef struct packed {
        logic       en_m;          // Update mepc and mcause
        logic       en_s;          // Update sepc and scause
        word_t      epc;           // Resume PC of the trapped instruction
        cause_t     cause;
        word_t      mstatus_next;  // Only the status fields are kept
        logic       status_we;     // Trap or return rewrites mstatus
        logic [4:0] pad;           // Rounds to a byte multiple
    } trap_commit_t;

    typedef struct packed {
        tvec_t mtvec;
        tvec_t stvec;
        word_t mepc;
        word_t sepc;
    } trap_view_t;                 // 128 bits

    typedef struct packed {
        logic   intr;       // An enabled interrupt is pending
        logic   intr_to_s;  // Taken in S-mode
        cause_t cause;
    } intr_sel_t;           // 34 bits

endpackage

`default_nettype wire
